/* vlog.f */
common/stream_fifo_pkg.sv
src/word_pack_fifo.sv
bulk_store/bulk_store.sv
src/out_word_fifo.sv
src/stream_fifo_top.sv
testbench/clk_gen.sv
testbench/tb_stream_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the stream FIFO testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -rf obj_dir "$log_file"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_stream_fifo \
	-f vlog.f -o sim_stream_fifo > "$log_file" 2>&1 \
	&& ./obj_dir/sim_stream_fifo >> "$log_file" 2>&1 \
	|| { cat "$log_file"; echo "Build or simulation error, see $log_file"; exit 1; }

cat "$log_file"

grep -q "Something failed" "$log_file" \
	&& { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

/* testbench/tb_stream_fifo.sv */
module tb_stream_fifo;

	timeunit 1ns;
	timeprecision 100ps;

	import stream_fifo_pkg::*;

	// Tests need well under 1000 cycles and the rest is margin
	localparam int CYCLE_LIMIT   = 2000;
	localparam int SETTLE_CYCLES = 6;
	localparam int SETTLE_LIMIT  = 200;

	logic         ti_clk;
	logic         reset;
	logic         sample_wr;
	sample_t      sample_in;
	logic         word_rd;
	sample_pair_t word_out;
	logic         block_rdy;
	word_count_t  fill_count;

	// Samples written and not yet read, oldest first
	sample_t      ref_q [$];
	sample_pair_t last_word;
	int           mismatch_count;
	int           failure_count;
	int           cycle_count = 0;

	clk_gen clk_gen_i (
		.ti_clk(ti_clk),
		.reset (reset)
	);

	stream_fifo_top dut_i (
		.ti_clk    (ti_clk),
		.reset     (reset),
		.sample_wr (sample_wr),
		.sample_in (sample_in),
		.word_rd   (word_rd),
		.word_out  (word_out),
		.block_rdy (block_rdy),
		.fill_count(fill_count)
	);

	always @(posedge ti_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout, the run was stopped after %0d cycles", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic write_samples(input int count);
		sample_t value;
		for (int i = 0; i < count; i++) begin
			value = sample_t'($urandom);
			@(posedge ti_clk);
			sample_wr <= 1'b1;
			sample_in <= value;
			ref_q.push_back(value);
		end
		@(posedge ti_clk);
		sample_wr <= 1'b0;
	endtask

	// Pairs in flight dip the count for a cycle, so wait for a steady value
	task automatic wait_fill_settle();
		int stable;
		int waited;
		stable = 0;
		waited = 0;
		while (stable < SETTLE_CYCLES && waited < SETTLE_LIMIT) begin
			@(negedge ti_clk);
			waited++;
			if (fill_count == word_count_t'(ref_q.size())) begin
				stable++;
			end else begin
				stable = 0;
			end
		end
		if (stable < SETTLE_CYCLES) begin
			$display("fill_count did not settle at %h, it reads %h", ref_q.size(), fill_count);
			failure_count++;
		end
	endtask

	// An empty output repeats the last word
	task automatic read_word_check();
		sample_pair_t expected;
		if (ref_q.size() >= 2) begin
			expected.lo = ref_q.pop_front();
			expected.hi = ref_q.pop_front();
		end else begin
			expected = last_word;
		end
		@(posedge ti_clk);
		word_rd <= 1'b1;
		@(posedge ti_clk);
		word_rd <= 1'b0;
		@(negedge ti_clk);
		check_value("word_out", word_out, expected);
		last_word = expected;
	endtask

	task automatic drain_pairs();
		while (ref_q.size() >= 2) begin
			read_word_check();
			wait_fill_settle();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic check_after_reset();
		@(negedge ti_clk);
		check_value("block_rdy", 32'(block_rdy), 32'h0);
		check_value("fill_count", fill_count, 32'h0);
		check_value("word_out", word_out, 32'h0);
		read_word_check();
		wait_fill_settle();
	endtask

	task automatic check_order_packing();
		write_samples(40);
		wait_fill_settle();
		drain_pairs();
	endtask

	task automatic check_block_ready();
		write_samples(8);
		wait_fill_settle();
		check_value("block_rdy", 32'(block_rdy), 32'h1);
		while (ref_q.size() / 2 >= OUT_BLOCK_DEF) begin
			read_word_check();
			wait_fill_settle();
		end
		check_value("block_rdy", 32'(block_rdy), 32'h0);
		drain_pairs();
	endtask

	task automatic check_back_pressure();
		write_samples(60);
		wait_fill_settle();
		check_value("out_count", dut_i.out_count, 32'd8);
		check_value("store_count", dut_i.store_count, 32'd22);
		check_value("block_rdy", 32'(block_rdy), 32'h1);
		drain_pairs();
		check_value("fill_count", fill_count, 32'h0);
	endtask

	task automatic check_odd_underflow();
		write_samples(3);
		wait_fill_settle();
		read_word_check();
		wait_fill_settle();
		// Only the odd sample is left, so the word repeats
		read_word_check();
		wait_fill_settle();
		write_samples(1);
		wait_fill_settle();
		drain_pairs();
		check_value("fill_count", fill_count, 32'h0);
	endtask

	initial begin
		sample_wr      = 1'b0;
		sample_in      = '0;
		word_rd        = 1'b0;
		last_word      = '0;
		mismatch_count = 0;
		failure_count  = 0;
		void'($urandom(32'h4c35));
		while (reset !== 1'b0) begin
			@(negedge ti_clk);
		end
		check_after_reset();
		check_order_packing();
		check_block_ready();
		check_back_pressure();
		check_odd_underflow();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* testbench/clk_gen.sv */
module clk_gen #(
	parameter int HALF_PERIOD_NS = 4,
	parameter int RESET_CYCLES   = 3
) (
	output logic ti_clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		ti_clk = 1'b0;
		forever #(HALF_PERIOD_NS) ti_clk = ~ti_clk;
	end

	// Reset is released after the last of its rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge ti_clk);
		reset <= 1'b0;
	end

endmodule

/* src/stream_fifo_top.sv */
module stream_fifo_top #(
	parameter int IN_DEPTH_LOG2    = stream_fifo_pkg::IN_DEPTH_LOG2_DEF,
	parameter int STORE_DEPTH_LOG2 = stream_fifo_pkg::STORE_DEPTH_LOG2_DEF,
	parameter int OUT_DEPTH_LOG2   = stream_fifo_pkg::OUT_DEPTH_LOG2_DEF,
	parameter int OUT_BLOCK        = stream_fifo_pkg::OUT_BLOCK_DEF
) (
	input  logic                          ti_clk,
	input  logic                          reset,
	input  logic                          sample_wr,
	input  stream_fifo_pkg::sample_t      sample_in,
	input  logic                          word_rd,
	output stream_fifo_pkg::sample_pair_t word_out,
	output logic                          block_rdy,
	output stream_fifo_pkg::word_count_t  fill_count
);

	import stream_fifo_pkg::*;

	logic         pair_avail;
	logic         pair_pop;
	sample_pair_t pair_head;
	logic         out_push;
	logic         out_room;
	sample_pair_t out_pair;
	word_count_t  in_count;
	word_count_t  store_count;
	word_count_t  out_count;

	word_pack_fifo #(
		.IN_DEPTH_LOG2(IN_DEPTH_LOG2)
	) word_pack_fifo_i (
		.ti_clk    (ti_clk),
		.reset     (reset),
		.sample_wr (sample_wr),
		.sample_in (sample_in),
		.pair_pop  (pair_pop),
		.pair_avail(pair_avail),
		.pair_head (pair_head),
		.in_count  (in_count)
	);

	bulk_store #(
		.STORE_DEPTH_LOG2(STORE_DEPTH_LOG2)
	) bulk_store_i (
		.ti_clk     (ti_clk),
		.reset      (reset),
		.pair_avail (pair_avail),
		.pair_head  (pair_head),
		.out_room   (out_room),
		.pair_pop   (pair_pop),
		.out_push   (out_push),
		.out_pair   (out_pair),
		.store_count(store_count)
	);

	out_word_fifo #(
		.OUT_DEPTH_LOG2(OUT_DEPTH_LOG2),
		.OUT_BLOCK     (OUT_BLOCK)
	) out_word_fifo_i (
		.ti_clk   (ti_clk),
		.reset    (reset),
		.out_push (out_push),
		.out_pair (out_pair),
		.word_rd  (word_rd),
		.out_room (out_room),
		.word_out (word_out),
		.block_rdy(block_rdy),
		.out_count(out_count)
	);

	// Samples held overall, store and output count pairs
	assign fill_count = in_count + (store_count << 1) + (out_count << 1);

endmodule

/* src/out_word_fifo.sv */
module out_word_fifo #(
	parameter int OUT_DEPTH_LOG2 = stream_fifo_pkg::OUT_DEPTH_LOG2_DEF,
	parameter int OUT_BLOCK      = stream_fifo_pkg::OUT_BLOCK_DEF
) (
	input  logic                          ti_clk,
	input  logic                          reset,
	input  logic                          out_push,
	input  stream_fifo_pkg::sample_pair_t out_pair,
	input  logic                          word_rd,
	output logic                          out_room,
	output stream_fifo_pkg::sample_pair_t word_out,
	output logic                          block_rdy,
	output stream_fifo_pkg::word_count_t  out_count
);

	import stream_fifo_pkg::*;

	localparam int DEPTH = 1 << OUT_DEPTH_LOG2;

	typedef logic [OUT_DEPTH_LOG2:0] out_ptr_t;

	sample_pair_t mem [DEPTH];
	out_ptr_t     wr_ptr;
	out_ptr_t     rd_ptr;
	out_ptr_t     fill;
	logic         do_read;

	assign fill      = wr_ptr - rd_ptr;
	assign out_room  = (fill != out_ptr_t'(DEPTH));
	assign out_count = word_count_t'(fill);
	// Pops on an empty FIFO are ignored
	assign do_read   = word_rd && (fill != '0);

	always_ff @(posedge ti_clk) begin
		if (out_push) begin
			mem[wr_ptr[OUT_DEPTH_LOG2-1:0]] <= out_pair;
		end
	end

	////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			word_out  <= '0;
			block_rdy <= 1'b0;
		end else begin
			if (out_push) begin
				wr_ptr <= wr_ptr + out_ptr_t'(1);
			end
			// word_out keeps the last word on underflow
			if (do_read) begin
				word_out <= mem[rd_ptr[OUT_DEPTH_LOG2-1:0]];
				rd_ptr   <= rd_ptr + out_ptr_t'(1);
			end
			block_rdy <= (out_count >= word_count_t'(OUT_BLOCK));
		end
	end

endmodule

/* bulk_store/bulk_store.sv */
module bulk_store #(
	parameter int STORE_DEPTH_LOG2 = stream_fifo_pkg::STORE_DEPTH_LOG2_DEF
) (
	input  logic                          ti_clk,
	input  logic                          reset,
	input  logic                          pair_avail,
	input  stream_fifo_pkg::sample_pair_t pair_head,
	input  logic                          out_room,
	output logic                          pair_pop,
	output logic                          out_push,
	output stream_fifo_pkg::sample_pair_t out_pair,
	output stream_fifo_pkg::word_count_t  store_count
);

	import stream_fifo_pkg::*;

	localparam int DEPTH = 1 << STORE_DEPTH_LOG2;

	// Free running pointers, the low bits address the RAM
	typedef logic [STORE_DEPTH_LOG2:0]   store_ptr_t;
	typedef logic [STORE_DEPTH_LOG2-1:0] store_addr_t;

	sample_pair_t mem [DEPTH];
	store_ptr_t   wr_ptr;
	store_ptr_t   rd_ptr;
	store_ptr_t   fill;
	store_addr_t  wr_addr;
	store_addr_t  rd_addr;
	xfer_state_t  state;
	xfer_state_t  state_next;
	logic         store_empty;
	logic         write_ok;
	logic         read_ok;

	assign fill        = wr_ptr - rd_ptr;
	assign store_empty = (wr_ptr == rd_ptr);
	assign wr_addr     = wr_ptr[STORE_DEPTH_LOG2-1:0];
	assign rd_addr     = rd_ptr[STORE_DEPTH_LOG2-1:0];
	assign store_count = word_count_t'(fill);

	////////////////////////////////////////////////////////////
	// Transfer decision
	////////////////////////////////////////////////////////////

	// state holds the move made on the last cycle. A read issued
	// last cycle is still in flight to the output FIFO, so two
	// reads never follow each other and out_room stays honest.
	assign write_ok = pair_avail;
	assign read_ok  = !store_empty && out_room && (state != XFER_READ);

	always_comb begin
		state_next = XFER_IDLE;
		if (write_ok && read_ok) begin
			// Both sides want service, take turns
			if (state == XFER_WRITE) begin
				state_next = XFER_READ;
			end else begin
				state_next = XFER_WRITE;
			end
		end else if (write_ok) begin
			state_next = XFER_WRITE;
		end else if (read_ok) begin
			state_next = XFER_READ;
		end
	end

	assign pair_pop = (state_next == XFER_WRITE);

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			state <= XFER_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Pair RAM and pointers
	////////////////////////////////////////////////////////////

	// No full check, a long stall laps the unread pairs
	always_ff @(posedge ti_clk) begin
		if (state_next == XFER_WRITE) begin
			mem[wr_addr] <= pair_head;
		end
	end

	// Output pair register, valid while out_push is high
	always_ff @(posedge ti_clk) begin
		if (state_next == XFER_READ) begin
			out_pair <= mem[rd_addr];
		end
	end

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			out_push <= 1'b0;
		end else begin
			out_push <= (state_next == XFER_READ);
			if (state_next == XFER_WRITE) begin
				wr_ptr <= wr_ptr + store_ptr_t'(1);
			end
			if (state_next == XFER_READ) begin
				rd_ptr <= rd_ptr + store_ptr_t'(1);
			end
		end
	end

endmodule

/* src/word_pack_fifo.sv */
module word_pack_fifo #(
	parameter int IN_DEPTH_LOG2 = stream_fifo_pkg::IN_DEPTH_LOG2_DEF
) (
	input  logic                         ti_clk,
	input  logic                         reset,
	input  logic                         sample_wr,
	input  stream_fifo_pkg::sample_t     sample_in,
	input  logic                         pair_pop,
	output logic                         pair_avail,
	output stream_fifo_pkg::sample_pair_t pair_head,
	output stream_fifo_pkg::word_count_t in_count
);

	import stream_fifo_pkg::*;

	localparam int DEPTH = 1 << IN_DEPTH_LOG2;

	// Pointers carry one extra bit so full and empty differ
	typedef logic [IN_DEPTH_LOG2:0]   in_ptr_t;
	typedef logic [IN_DEPTH_LOG2-1:0] in_addr_t;

	sample_t  mem [DEPTH];
	in_ptr_t  wr_ptr;
	in_ptr_t  rd_ptr;
	in_ptr_t  fill;
	in_addr_t rd_addr_lo;
	in_addr_t rd_addr_hi;
	logic     full;
	logic     do_write;

	assign fill     = wr_ptr - rd_ptr;
	assign full     = (fill == in_ptr_t'(DEPTH));
	// Writes into a full FIFO are lost
	assign do_write = sample_wr && !full;

	////////////////////////////////////////////////////////////
	// Sample storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (do_write) begin
			mem[wr_ptr[IN_DEPTH_LOG2-1:0]] <= sample_in;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + in_ptr_t'(1);
			end
			// Read side always moves a whole pair
			if (pair_pop) begin
				rd_ptr <= rd_ptr + in_ptr_t'(2);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pair view of the head
	////////////////////////////////////////////////////////////

	// rd_ptr is always even, so the pair sits at rd and rd+1
	assign rd_addr_lo = rd_ptr[IN_DEPTH_LOG2-1:0];
	assign rd_addr_hi = rd_addr_lo | in_addr_t'(1);

	assign pair_head.lo = mem[rd_addr_lo];
	assign pair_head.hi = mem[rd_addr_hi];

	// An odd sample waits here for its partner
	assign pair_avail = (fill >= in_ptr_t'(2));
	assign in_count   = word_count_t'(fill);

endmodule

/* common/stream_fifo_pkg.sv */
package stream_fifo_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// One acquisition sample
	typedef logic [15:0] sample_t;

	// Two samples packed into one host word, lo arrived first
	typedef struct packed {
		sample_t hi;
		sample_t lo;
	} sample_pair_t;

	// Occupancy in samples or pairs, as the port says
	typedef logic [31:0] word_count_t;

	// Transfer machine of the bulk store
	typedef enum logic [1:0] {
		XFER_IDLE,
		XFER_WRITE,
		XFER_READ
	} xfer_state_t;

	////////////////////////////////////////////////////////////
	// Default sizes
	////////////////////////////////////////////////////////////

	localparam int IN_DEPTH_LOG2_DEF    = 4;    // 16 samples
	localparam int STORE_DEPTH_LOG2_DEF = 6;    // 64 pairs
	localparam int OUT_DEPTH_LOG2_DEF   = 3;    // 8 pairs
	localparam int OUT_BLOCK_DEF        = 4;    // Block size in pairs

endpackage
